// File: compile.f
rtl/adsPkg.sv
rtl/i2cBitEngine.sv
rtl/adsSequencer.sv
rtl/channelScanner.sv
rtl/adcScanTop.sv
tests/adsSlaveModel.sv
tests/adcScanTb_assert.sv
tests/adcScanTb.sv

// File: tests/adcScanTb.sv
// --------------------
// Two full scans against the ADS1115 model, about 2.5M time units
// --------------------
`default_nettype none

module adcScanTb;
    import adsPkg::*;

    localparam int updateTimeout = 60000; // Cycles per result
    localparam int numUpdates    = 8;

    logic        clk;
    logic        arstN;
    wire         sda;
    logic        scl;
    adcResults_t results;
    logic        resultValid;
    int          errorCount;
    int          checkCount;
    bit          timedOut;

    pullup (sda);

    adcScanTop i_dut (
        .clk         (clk),
        .arstN       (arstN),
        .sda         (sda),
        .scl         (scl),
        .results     (results),
        .resultValid (resultValid)
    );

    adsSlaveModel i_slave (
        .scl (scl),
        .sda (sda)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Negative codes clamp to zero, else bits 14 to 3
    function automatic logic [11:0] expectedValue(input logic [15:0] code);
        if (code[15]) begin
            return 12'd0;
        end else begin
            return code[14:3];
        end
    endfunction

    function automatic logic [11:0] fieldOf(input adcResults_t r, input int ch);
        case (ch)
            0:       return r.chan0;
            1:       return r.chan1;
            2:       return r.chan2;
            default: return r.chan3;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [47:0] want,
                              input logic [47:0] got);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, want, got);
        end
    endtask

    task automatic fillTables();
        int negIdx;
        int maxIdx;
        negIdx = $urandom % 4;
        maxIdx = (negIdx + 1 + $urandom % 3) % 4;
        for (int i = 0; i < 4; i++) begin
            i_slave.codeTable[i] = 16'($urandom);
        end
        i_slave.codeTable[negIdx] = {1'b1, 15'($urandom)};
        i_slave.codeTable[maxIdx] = 16'h7fff; // Full scale
        for (int i = 0; i < 8; i++) begin
            i_slave.busyTable[i] = 1 + $urandom % 3;
        end
    endtask

    task automatic checkIdle();
        checkValue("scl", 1, scl);
        checkValue("sda", 1, sda);
        checkValue("resultValid", 0, resultValid);
        checkValue("results", 0, results);
    endtask

    task automatic waitUpdate(output bit expired);
        int cycles;
        cycles  = 0;
        expired = 1'b0;
        while (resultValid !== 1'b1 && !expired) begin
            @(negedge clk);
            cycles++;
            if (cycles > updateTimeout) begin
                expired = 1'b1;
            end
        end
        if (expired) begin
            errorCount++;
            $display("ERROR at %0t: no result update within %0d cycles", $time, updateTimeout);
        end
    endtask

    task automatic checkUpdate(input int n, input adcResults_t prev);
        int          ch;
        logic [11:0] want;
        ch   = n % 4;
        want = expectedValue(i_slave.codeTable[ch]);
        for (int k = 0; k < 4; k++) begin
            if (k == ch) begin
                checkValue($sformatf("results.chan%0d", k), want, fieldOf(results, k));
            end else begin
                checkValue($sformatf("results.chan%0d", k), fieldOf(prev, k),
                           fieldOf(results, k));
            end
        end
        // OS, single-ended mux, gain 001, single-shot
        checkValue("config MSB", {2'b11, ch[1:0], 4'b0011}, i_slave.cfgHi);
        checkValue("config LSB", 8'h83, i_slave.cfgLo);
        checkValue("poll reads", i_slave.lastBusy + 1, i_slave.readPolls);
        checkValue("conversion reads", n + 1, i_slave.convReads);
    endtask

    initial begin
        adcResults_t prev;
        int          seedVal;
        errorCount = 0;
        checkCount = 0;
        timedOut   = 1'b0;
        arstN      = 1'b0;
        seedVal    = $urandom(40315);
        fillTables();
        repeat (5) begin
            @(negedge clk);
            checkIdle();
        end
        arstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkIdle();
        end
        prev = '0;
        for (int n = 0; n < numUpdates && !timedOut; n++) begin
            waitUpdate(timedOut);
            if (!timedOut) begin
                checkUpdate(n, prev);
                prev = results;
                @(negedge clk);
                checkValue("resultValid pulse", 0, resultValid);
            end
        end
        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/adcScanTb_assert.sv
// --------------------
// Bound into adcScanTop, where the sequencer handshake and scl meet
// --------------------
`default_nettype none

module adcScanTb_assert (
    input logic            clk,
    input logic            arstN,
    input adsPkg::i2cCmd_t cmd,
    input logic            cmdValid,
    input logic            convReq,
    input logic            convDone,
    input logic            scl
);

    cmdStable: assert property (@(posedge clk) disable iff (!arstN)
        cmdValid && $past(cmdValid) |-> $stable(cmd))
        else $error("cmd changed while cmdValid was high");

    doneNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(convDone) |-> convReq)
        else $error("convDone rose with convReq low");

    // First reset edge skipped, flops may settle there
    sclInReset: assert property (@(posedge clk)
        !arstN ##1 !arstN |-> scl)
        else $error("scl low during reset");

endmodule

bind adcScanTop adcScanTb_assert i_assert (
    .clk      (clk),
    .arstN    (arstN),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .convReq  (convReq),
    .convDone (convDone),
    .scl      (scl)
);

`default_nettype wire

// File: tests/adsSlaveModel.sv
// --------------------
// Answers only at address 1001001, no clock stretching
// Tables are filled by the testbench before reset ends
// --------------------
`default_nettype none

module adsSlaveModel (
    input  logic scl,
    inout  wire  sda
);

    localparam logic [6:0] devAddr = 7'b1001001;

    logic [15:0] codeTable [4];  // Conversion code per channel
    int          busyTable [8];  // Not-ready polls per conversion
    logic [7:0]  ptrReg = 8'h00;
    logic [7:0]  cfgHi = 8'h85;
    logic [7:0]  cfgLo = 8'h83;
    logic [1:0]  convChan = 2'd0;
    int          busyLeft = 0;
    int          lastBusy = 0;
    int          pollReads = 0;
    int          readPolls = 0;  // Polls seen before the conversion read
    int          convReads = 0;
    int          convCount = 0;
    logic        drvLow = 1'b0;
    logic        inFrame = 1'b0;
    logic        addrHit = 1'b0;
    logic        isRead = 1'b0;
    logic [7:0]  rxSh = 8'h00;
    logic [15:0] txWord = 16'h0000;
    int          bitIdx = 0;
    int          byteIdx = 0;

    assign sda = drvLow ? 1'b0 : 1'bz;

    // START
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            inFrame = 1'b1;
            bitIdx  = -1;     // First SCL fall moves to bit 0
            byteIdx = 0;
            addrHit = 1'b0;
            isRead  = 1'b0;
            drvLow  = 1'b0;
        end
    end

    // STOP
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            inFrame = 1'b0;
            drvLow  = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (inFrame && bitIdx >= 0 && bitIdx < 8 && !(isRead && byteIdx > 0)) begin
            rxSh = {rxSh[6:0], sda};
            if (bitIdx == 7 && byteIdx == 0) begin
                addrHit = (rxSh[7:1] == devAddr);
                isRead  = rxSh[0];
                if (addrHit && isRead && ptrReg == 8'h01) begin
                    txWord    = {busyLeft == 0, cfgHi[6:0], cfgLo}; // OS low while busy
                    pollReads = pollReads + 1;
                    if (busyLeft > 0) begin
                        busyLeft = busyLeft - 1;
                    end
                end else if (addrHit && isRead) begin
                    txWord    = codeTable[convChan];
                    readPolls = pollReads;
                    convReads = convReads + 1;
                end
            end else if (bitIdx == 7 && addrHit) begin
                if (byteIdx == 1) begin
                    ptrReg = rxSh;
                end else if (byteIdx == 2 && ptrReg == 8'h01) begin
                    cfgHi = rxSh;
                end else if (byteIdx == 3 && ptrReg == 8'h01) begin
                    cfgLo = rxSh;
                    if (cfgHi[7]) begin
                        convChan  = cfgHi[5:4];
                        busyLeft  = busyTable[convCount % 8];
                        lastBusy  = busyLeft;
                        pollReads = 0;
                        convCount = convCount + 1;
                    end
                end
            end
        end
    end

    always @(negedge scl) begin
        if (inFrame) begin
            if (bitIdx == 8) begin
                bitIdx  = 0;
                byteIdx = byteIdx + 1;
            end else begin
                bitIdx = bitIdx + 1;
            end
            drvLow = 1'b0;
            if (bitIdx == 8) begin
                drvLow = addrHit && (byteIdx == 0 || !isRead); // Device ACK
            end else if (addrHit && isRead && byteIdx > 0 && byteIdx < 3) begin
                drvLow = !txWord[15 - 8 * (byteIdx - 1) - bitIdx];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/adcScanTop.sv
// --------------------
// SDA needs an external pull-up
// --------------------
`default_nettype none

module adcScanTop (
    input  logic                clk,
    input  logic                arstN,
    inout  wire                 sda,
    output logic                scl,
    output adsPkg::adcResults_t results,
    output logic                resultValid
);
    import adsPkg::*;

    logic        convReq;
    logic        convDone;
    logic [1:0]  channel;
    logic [15:0] rawCode;
    i2cCmd_t     cmd;
    logic        cmdValid;
    logic        cmdDone;
    logic [7:0]  rxByte;
    logic        sdaOut;
    logic        sdaDrive;

    channelScanner i_scanner (
        .clk         (clk),
        .arstN       (arstN),
        .convDone    (convDone),
        .rawCode     (rawCode),
        .convReq     (convReq),
        .channel     (channel),
        .results     (results),
        .resultValid (resultValid)
    );

    adsSequencer i_sequencer (
        .clk      (clk),
        .arstN    (arstN),
        .convReq  (convReq),
        .channel  (channel),
        .cmdDone  (cmdDone),
        .rxByte   (rxByte),
        .convDone (convDone),
        .rawCode  (rawCode),
        .cmd      (cmd),
        .cmdValid (cmdValid)
    );

    i2cBitEngine i_engine (
        .clk      (clk),
        .arstN    (arstN),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .sdaIn    (sda),
        .cmdDone  (cmdDone),
        .scl      (scl),
        .sdaOut   (sdaOut),
        .sdaDrive (sdaDrive),
        .rxByte   (rxByte)
    );

    // High level comes from the pull-up
    assign sda = (sdaDrive && !sdaOut) ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

// File: rtl/channelScanner.sv
// --------------------
// Results are overwritten in place, no back-pressure
// --------------------
`default_nettype none

module channelScanner (
    input  logic                clk,
    input  logic                arstN,
    input  logic                convDone,
    input  logic [15:0]         rawCode,
    output logic                convReq,
    output logic [1:0]          channel,
    output adsPkg::adcResults_t results,
    output logic                resultValid
);
    import adsPkg::*;

    typedef enum logic [1:0] {
        scanRequest,
        scanWaitStart,
        scanWaitDone
    } scanState_e;

    scanState_e            state;
    logic [resultBits-1:0] clamped;

    // Negative codes read as zero
    assign clamped = rawCode[15] ? '0 : rawCode[14:3];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= scanRequest;
            convReq     <= 1'b0;
            channel     <= 2'd0;
            results     <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            case (state)
                scanRequest: begin
                    convReq <= 1'b1;
                    state   <= scanWaitStart;
                end
                scanWaitStart: begin
                    if (!convDone) begin
                        state <= scanWaitDone;
                    end
                end
                default: begin
                    if (convDone) begin
                        case (channel)
                            2'd0:    results.chan0 <= clamped;
                            2'd1:    results.chan1 <= clamped;
                            2'd2:    results.chan2 <= clamped;
                            default: results.chan3 <= clamped;
                        endcase
                        resultValid <= 1'b1;
                        convReq     <= 1'b0;
                        channel     <= channel + 2'd1; // Wraps 3 to 0
                        state       <= scanRequest;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/adsSequencer.sv
// --------------------
// Polls the config register until OS is set, no limit on the number of polls
// --------------------
`default_nettype none

module adsSequencer (
    input  logic            clk,
    input  logic            arstN,
    input  logic            convReq,
    input  logic [1:0]      channel,
    input  logic            cmdDone,
    input  logic [7:0]      rxByte,
    output logic            convDone,
    output logic [15:0]     rawCode,
    output adsPkg::i2cCmd_t cmd,
    output logic            cmdValid
);
    import adsPkg::*;

    typedef enum logic [2:0] {
        seqIdle,
        seqRun,
        seqWaitEng,
        seqNext,
        seqDelay,
        seqDone
    } seqState_e;

    typedef enum logic [1:0] {
        taskSetup,
        taskPoll,
        taskPointer,
        taskRead
    } adsTask_e;

    seqState_e            state;
    adsTask_e             curTask;
    logic [2:0]           step;
    logic [pollDelay-1:0] waitCnt;
    logic                 engStarted;
    i2cCmd_t              stepCmd;
    logic                 isDelay;
    logic                 lastStep;
    logic                 firstRead;

    // Command list of each task
    always_comb begin
        stepCmd  = '{op: opStart, data: 8'h00};
        isDelay  = 1'b0;
        lastStep = 1'b0;
        case (curTask)
            taskSetup: begin
                case (step)
                    3'd0: stepCmd.op = opStart;
                    3'd1: stepCmd = '{op: opWriteByte, data: {adsAddr, 1'b0}};
                    3'd2: stepCmd = '{op: opWriteByte, data: ptrConfig};
                    3'd3: stepCmd = '{op: opWriteByte, data: {2'b11, channel, cfgModeBits}};
                    3'd4: stepCmd = '{op: opWriteByte, data: cfgLsb};
                    default: begin
                        stepCmd.op = opStop;
                        lastStep   = 1'b1;
                    end
                endcase
            end
            taskPoll: begin
                case (step)
                    3'd0:       isDelay = 1'b1;
                    3'd1:       stepCmd.op = opStart;
                    3'd2:       stepCmd = '{op: opWriteByte, data: {adsAddr, 1'b1}};
                    3'd3, 3'd4: stepCmd.op = opReadByte;
                    default: begin
                        stepCmd.op = opStop;
                        lastStep   = 1'b1;
                    end
                endcase
            end
            taskPointer: begin
                case (step)
                    3'd0: stepCmd.op = opStart;
                    3'd1: stepCmd = '{op: opWriteByte, data: {adsAddr, 1'b0}};
                    3'd2: stepCmd = '{op: opWriteByte, data: ptrConversion};
                    default: begin
                        stepCmd.op = opStop;
                        lastStep   = 1'b1;
                    end
                endcase
            end
            default: begin
                case (step)
                    3'd0:       stepCmd.op = opStart;
                    3'd1:       stepCmd = '{op: opWriteByte, data: {adsAddr, 1'b1}};
                    3'd2, 3'd3: stepCmd.op = opReadByte;
                    default: begin
                        stepCmd.op = opStop;
                        lastStep   = 1'b1;
                    end
                endcase
            end
        endcase
    end

    assign firstRead = (curTask == taskPoll && step == 3'd3) ||
                       (curTask == taskRead && step == 3'd2);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= seqIdle;
            curTask    <= taskSetup;
            step       <= '0;
            waitCnt    <= '0;
            engStarted <= 1'b0;
            convDone   <= 1'b1;
            rawCode    <= '0;
            cmd        <= '{op: opStart, data: 8'h00};
            cmdValid   <= 1'b0;
        end else begin
            case (state)
                seqIdle: begin
                    if (convReq) begin
                        convDone <= 1'b0;
                        curTask  <= taskSetup;
                        step     <= '0;
                        state    <= seqRun;
                    end
                end
                seqRun: begin
                    if (isDelay) begin
                        waitCnt <= '0;
                        state   <= seqDelay;
                    end else begin
                        cmd        <= stepCmd;
                        cmdValid   <= 1'b1;
                        engStarted <= 1'b0;
                        state      <= seqWaitEng;
                    end
                end
                seqWaitEng: begin
                    if (!cmdDone) begin
                        engStarted <= 1'b1;
                    end else if (engStarted) begin
                        cmdValid <= 1'b0;
                        state    <= seqNext;
                        if (cmd.op == opReadByte) begin
                            if (firstRead) begin
                                rawCode[15:8] <= rxByte;
                            end else begin
                                rawCode[7:0] <= rxByte;
                            end
                        end
                    end
                end
                seqNext: begin
                    state <= seqRun;
                    if (!lastStep) begin
                        step <= step + 3'd1;
                    end else begin
                        step <= '0;
                        case (curTask)
                            taskSetup:   curTask <= taskPoll;
                            taskPoll: begin
                                if (rawCode[15]) begin
                                    curTask <= taskPointer; // OS set, conversion finished
                                end
                            end
                            taskPointer: curTask <= taskRead;
                            default: begin
                                convDone <= 1'b1;
                                state    <= seqDone;
                            end
                        endcase
                    end
                end
                seqDelay: begin
                    waitCnt <= waitCnt + 1'b1;
                    if (waitCnt == '1) begin
                        state <= seqNext;
                    end
                end
                default: begin
                    if (!convReq) begin
                        state <= seqIdle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2cBitEngine.sv
// --------------------
// Reads always answer with ACK, the device ACK after writes is not checked
// --------------------
`default_nettype none

module i2cBitEngine (
    input  logic            clk,
    input  logic            arstN,
    input  adsPkg::i2cCmd_t cmd,
    input  logic            cmdValid,
    input  logic            sdaIn,
    output logic            cmdDone,
    output logic            scl,
    output logic            sdaOut,
    output logic            sdaDrive,
    output logic [7:0]      rxByte
);
    import adsPkg::*;

    typedef enum logic [2:0] {
        engIdle,
        engStart,
        engStop,
        engWrite,
        engRcvAck,
        engRead,
        engSendAck,
        engDone
    } engState_e;

    localparam logic [divBits-1:0] lastPhase = '1;
    localparam logic [divBits-1:0] midHigh   = {1'b1, {(divBits - 1){1'b0}}};

    engState_e          state;
    logic [divBits-1:0] phase;
    logic [1:0]         quarter;
    logic               sclBit;
    logic [2:0]         bitCnt;
    logic [7:0]         shReg;

    assign quarter = phase[divBits-1 -: 2];
    assign sclBit  = (quarter == 2'd1) || (quarter == 2'd2); // High in the middle half

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= engIdle;
            phase    <= '0;
            bitCnt   <= '0;
            cmdDone  <= 1'b1;
            scl      <= 1'b1;
            sdaOut   <= 1'b1;
            sdaDrive <= 1'b0;
        end else begin
            case (state)
                engIdle: begin
                    if (cmdValid) begin
                        cmdDone <= 1'b0;
                        phase   <= '0;
                        bitCnt  <= '0;
                        case (cmd.op)
                            opStart:     state <= engStart;
                            opStop:      state <= engStop;
                            opReadByte:  state <= engRead;
                            default:     state <= engWrite;
                        endcase
                    end
                end
                engStart: begin
                    sdaDrive <= 1'b1;
                    phase    <= phase + 1'b1;
                    case (quarter)
                        2'd0: begin
                            scl    <= 1'b1;
                            sdaOut <= 1'b1;
                        end
                        2'd1:    sdaOut <= 1'b0; // SDA falls while SCL high
                        2'd2:    scl <= 1'b0;
                        default: ;
                    endcase
                    if (phase == lastPhase) begin
                        cmdDone <= 1'b1;
                        state   <= engDone;
                    end
                end
                engStop: begin
                    sdaDrive <= 1'b1;
                    phase    <= phase + 1'b1;
                    case (quarter)
                        2'd0: begin
                            scl    <= 1'b0;
                            sdaOut <= 1'b0;
                        end
                        2'd1:    scl <= 1'b1;
                        2'd2:    sdaOut <= 1'b1; // SDA rises while SCL high
                        default: ;
                    endcase
                    if (phase == lastPhase) begin
                        cmdDone <= 1'b1;
                        state   <= engDone;
                    end
                end
                engWrite: begin
                    sdaDrive <= 1'b1;
                    sdaOut   <= shReg[7];
                    scl      <= sclBit;
                    phase    <= phase + 1'b1;
                    if (phase == lastPhase) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) begin
                            state <= engRcvAck;
                        end
                    end
                end
                engRead: begin
                    sdaDrive <= 1'b0;
                    sdaOut   <= 1'b1;
                    scl      <= sclBit;
                    phase    <= phase + 1'b1;
                    if (phase == lastPhase) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) begin
                            state <= engSendAck;
                        end
                    end
                end
                engRcvAck, engSendAck: begin
                    sdaDrive <= (state == engSendAck); // Device acks after a write
                    sdaOut   <= (state == engRcvAck);
                    scl      <= sclBit;
                    phase    <= phase + 1'b1;
                    if (phase == lastPhase) begin
                        cmdDone <= 1'b1;
                        state   <= engDone;
                    end
                end
                default: begin
                    if (!cmdValid) begin
                        state <= engIdle;
                    end
                end
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == engIdle && cmdValid) begin
            shReg <= cmd.data;
        end else if (state == engWrite && phase == lastPhase) begin
            shReg <= {shReg[6:0], 1'b0}; // MSB first
        end
        if (state == engRead && phase == midHigh) begin
            rxByte <= {rxByte[6:0], sdaIn};
        end
    end

endmodule

`default_nettype wire

// File: rtl/adsPkg.sv
// --------------------
// ADS1115 at address 1001001 only, with fixed ±4.096 V range and 128 SPS
// Bus timing assumes a plain I2C slave with no clock stretching
// --------------------
`default_nettype none

package adsPkg;

    // Bit engine operations
    typedef enum logic [1:0] {
        opStart,
        opStop,
        opReadByte,
        opWriteByte
    } i2cOp_e;

    // One command for the bit engine, 10 bits
    typedef struct packed {
        i2cOp_e     op;
        logic [7:0] data;
    } i2cCmd_t;

    // Clamped results, chan0 sits in the low bits
    typedef struct packed {
        logic [11:0] chan3;
        logic [11:0] chan2;
        logic [11:0] chan1;
        logic [11:0] chan0;
    } adcResults_t;

    // 7-bit device address, ADDR pin tied to VDD
    localparam logic [6:0] adsAddr = 7'b1001001;

    // Register pointers
    localparam logic [7:0] ptrConversion = 8'h00;
    localparam logic [7:0] ptrConfig     = 8'h01;

    // Gain 001 (±4.096 V) then single-shot mode
    localparam logic [3:0] cfgModeBits = 4'b0011;

    // 128 SPS, comparator off
    localparam logic [7:0] cfgLsb = 8'b100_00011;

    // Engine phase counter width, 128 clocks per bus bit
    localparam int divBits = 7;

    // Wait counter width between ready polls
    localparam int pollDelay = 8;

    // Width of a clamped result
    localparam int resultBits = 12;

endpackage

`default_nettype wire
